//--- project.f
+incdir+hdl
hdl/md_pkg.sv
hdl/md_ctrl.sv
hdl/md_step_counter.sv
hdl/md_multiplier.sv
hdl/md_divider.sv
hdl/hilo_reg.sv
hdl/muldiv_unit.sv
tests/tb_muldiv.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_muldiv \
		-f project.f -o tb_muldiv
	./obj_dir/tb_muldiv > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/tb_muldiv.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defs.svh"

module tb_muldiv import md_pkg::*; ();

	localparam int W = `MD_WIDTH;
	localparam int N_RAND = 12; // rounds over all nine ops
	localparam int N_OPS = 9 * N_RAND + 12;
	localparam int WATCHDOG_NS = (N_OPS * 40 + 100) * 20;

	logic clk;
	logic rst;
	logic start;
	logic kill;
	md_req_t req;
	hilo_wr_t hilo_wr;
	logic rd_hi;
	logic busy;
	logic [W-1:0] hilo_out;
	logic [W-1:0] mul_out;

	logic [2*W-1:0] exp_hilo; // reference HI/LO
	logic [W-1:0] exp_mul;
	int exp_len = 0;
	int busy_cycles = 0;
	int checks = 0;
	int val_errors = 0;
	int proto_errors = 0;

	md_op_e op_list [9] = '{OP_MULT, OP_MULTU, OP_MUL, OP_DIV, OP_DIVU,
		OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};

	muldiv_unit dut_i (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.kill     (kill),
		.req      (req),
		.hilo_wr  (hilo_wr),
		.rd_hi    (rd_hi),
		.busy     (busy),
		.hilo_out (hilo_out),
		.mul_out  (mul_out)
	);

	always #10 clk = ~clk;

	function automatic bit is_div(input md_op_e op);
		return (op == OP_DIV) || (op == OP_DIVU);
	endfunction

	// length of the current busy stretch, and what the accepted op should take
	always @(posedge clk) begin
		if (!busy)
			busy_cycles <= 0;
		else
			busy_cycles <= busy_cycles + 1;
		if (rst && start && !busy && !kill)
			exp_len <= is_div(req.op) ? `MD_DIV_STEPS + 2 : `MD_MUL_CYCLES;
	end

	a_busy_len: assert property (@(posedge clk) disable iff (!rst)
		$fell(busy) |-> (busy_cycles == exp_len))
		else begin
			proto_errors++;
			$display("busy lasted %0d cycles where %0d were expected",
				$sampled(busy_cycles), $sampled(exp_len));
		end

	a_kill_idle: assert property (@(posedge clk) disable iff (!rst)
		(start && kill && !busy) |=> !busy)
		else begin
			proto_errors++;
			$display("a start with kill high was accepted while idle");
		end

	function automatic logic [2*W-1:0] full_product(input md_op_e op,
			input logic [W-1:0] a, input logic [W-1:0] b);
		logic [2*W-1:0] ax;
		logic [2*W-1:0] bx;
		bit sgn;
		sgn = (op == OP_MULT) || (op == OP_MADD) || (op == OP_MSUB) || (op == OP_MUL);
		ax = sgn ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
		bx = sgn ? {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
		return ax * bx; // low 64 bits are right for both kinds
	endfunction

	function automatic void apply_model(input md_op_e op,
			input logic [W-1:0] a, input logic [W-1:0] b);
		logic [2*W-1:0] p;
		logic [W-1:0] am;
		logic [W-1:0] bm;
		logic [W-1:0] q;
		logic [W-1:0] r;
		bit sgn;
		p = full_product(op, a, b);
		sgn = (op == OP_DIV);
		am = (sgn && a[W-1]) ? -a : a;
		bm = (sgn && b[W-1]) ? -b : b;
		if (bm == '0) begin
			q = '1;
			r = am;
		end else begin
			q = am / bm;
			r = am % bm;
		end
		if (sgn && (a[W-1] ^ b[W-1]))
			q = -q;
		if (sgn && a[W-1])
			r = -r; // remainder takes the dividend's sign
		case (op)
			OP_MULT, OP_MULTU: exp_hilo = p;
			OP_MADD, OP_MADDU: exp_hilo = exp_hilo + p;
			OP_MSUB, OP_MSUBU: exp_hilo = exp_hilo - p;
			OP_DIV, OP_DIVU:   exp_hilo = {r, q};
			default:           exp_mul = p[W-1:0];
		endcase
	endfunction

	function automatic logic [W-1:0] pick_operand();
		int unsigned r;
		r = $urandom % 8;
		case (r)
			0: return 32'h0000_0000;
			1: return 32'hffff_ffff;
			2: return 32'h8000_0000;
			3: return 32'h7fff_ffff;
			default: return $urandom;
		endcase
	endfunction

	task automatic check_word(input string name, input logic [W-1:0] got,
			input logic [W-1:0] exp);
		checks++;
		assert (got === exp)
		else begin
			val_errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_state(input string what);
		rd_hi = 1'b1;
		#1;
		check_word({"hilo_out(hi) after ", what}, hilo_out, exp_hilo[2*W-1:W]);
		rd_hi = 1'b0;
		#1;
		check_word({"hilo_out(lo) after ", what}, hilo_out, exp_hilo[W-1:0]);
		check_word({"mul_out after ", what}, mul_out, exp_mul);
	endtask

	task automatic write_hilo(input bit sel_hi, input logic [W-1:0] data);
		@(posedge clk);
		#2;
		hilo_wr = '{en: 1'b1, sel_hi: sel_hi, data: data};
		@(posedge clk);
		#2;
		hilo_wr.en = 1'b0;
		if (sel_hi)
			exp_hilo[2*W-1:W] = data;
		else
			exp_hilo[W-1:0] = data;
	endtask

	task automatic run_op(input md_op_e op, input logic [W-1:0] a,
			input logic [W-1:0] b, input bit noise);
		int waited;
		@(posedge clk);
		#2;
		req = '{op: op, a: a, b: b};
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		if (noise) begin
			// restart, direct write, then a killed start, all while busy
			req = '{op: OP_MULTU, a: ~a, b: ~b};
			start = 1'b1;
			hilo_wr = '{en: 1'b1, sel_hi: 1'b1, data: 32'hdead_beef};
			@(posedge clk);
			#2;
			kill = 1'b1;
			hilo_wr.sel_hi = 1'b0;
			@(posedge clk);
			#2;
			start = 1'b0;
			kill = 1'b0;
			hilo_wr.en = 1'b0;
		end
		waited = 0;
		while (busy && waited < 60) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (busy) begin
			proto_errors++;
			$display("busy did not fall after %s", op.name());
		end
		apply_model(op, a, b);
		check_state(op.name());
	endtask

	initial begin
		#WATCHDOG_NS;
		$display("watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		md_op_e op;
		logic [W-1:0] a;
		logic [W-1:0] b;
		void'($urandom(32'h630f5b36));
		clk = 1'b0;
		rst = 1'b0;
		start = 1'b0;
		kill = 1'b0;
		req = '0;
		hilo_wr = '0;
		rd_hi = 1'b0;
		exp_hilo = '0;
		exp_mul = '0;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b1;

		check_state("reset");
		if (busy) begin
			proto_errors++;
			$display("busy is high right after reset");
		end

		// edge operands
		run_op(OP_MULT, 32'h8000_0000, 32'h8000_0000, 1'b0);
		run_op(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		run_op(OP_MUL, 32'hffff_ffff, 32'h0000_0002, 1'b0);
		run_op(OP_DIVU, 32'h1234_5678, 32'h0000_0000, 1'b0); // zero divisor
		run_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0);
		run_op(OP_DIV, 32'hffff_fff9, 32'h0000_0002, 1'b1);
		run_op(OP_DIV, 32'h0000_0007, 32'hffff_fffe, 1'b0);

		// start with kill while idle
		@(posedge clk);
		#2;
		req = '{op: OP_MULT, a: 32'h1111_1111, b: 32'h2222_2222};
		start = 1'b1;
		kill = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		kill = 1'b0;
		@(posedge clk);
		#2;
		check_state("killed start");

		for (int i = 0; i < N_RAND; i++) begin
			foreach (op_list[k]) begin
				op = op_list[k];
				a = pick_operand();
				b = pick_operand();
				if (op == OP_DIV && b == '0)
					b = 32'd3; // signed zero divisor has no defined result
				if (op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU}) begin
					write_hilo(1'b1, $urandom);
					write_hilo(1'b0, $urandom);
				end
				run_op(op, a, b, (i % 3) == 1);
			end
		end

		repeat (2) @(posedge clk);
		$display("checks: %0d, value errors: %0d, protocol errors: %0d",
			checks, val_errors, proto_errors);
		if (val_errors == 0 && proto_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/muldiv_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defs.svh"

module muldiv_unit import md_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 start,
	input  wire logic                 kill,
	input  wire md_req_t              req,
	input  wire hilo_wr_t             hilo_wr,
	input  wire logic                 rd_hi,
	output logic                      busy,
	output logic [`MD_WIDTH-1:0]      hilo_out,
	output logic [`MD_WIDTH-1:0]      mul_out
);

	logic go_mul;
	logic go_div;
	logic finish;
	logic last;
	logic [5:0] step;
	md_op_e op_q;
	logic [`MD_WIDTH-1:0] a_q;
	logic [`MD_WIDTH-1:0] b_q;
	logic [2*`MD_WIDTH-1:0] product;
	logic [`MD_WIDTH-1:0] quotient;
	logic [`MD_WIDTH-1:0] remainder;

	md_ctrl ctrl_i (
		.clk    (clk),
		.rst    (rst),
		.start  (start),
		.kill   (kill),
		.req    (req),
		.last   (last),
		.busy   (busy),
		.go_mul (go_mul),
		.go_div (go_div),
		.finish (finish),
		.op_q   (op_q),
		.a_q    (a_q),
		.b_q    (b_q)
	);

	md_step_counter cnt_i (
		.clk    (clk),
		.rst    (rst),
		.go_mul (go_mul),
		.go_div (go_div),
		.step   (step),
		.last   (last)
	);

	md_multiplier mul_i (
		.clk     (clk),
		.rst     (rst),
		.go_mul  (go_mul),
		.op_q    (op_q),
		.a_q     (a_q),
		.b_q     (b_q),
		.step    (step),
		.product (product)
	);

	md_divider div_i (
		.clk       (clk),
		.rst       (rst),
		.go_div    (go_div),
		.op_q      (op_q),
		.a_q       (a_q),
		.b_q       (b_q),
		.step      (step),
		.quotient  (quotient),
		.remainder (remainder)
	);

	hilo_reg hilo_i (
		.clk       (clk),
		.rst       (rst),
		.busy      (busy),
		.finish    (finish),
		.op_q      (op_q),
		.product   (product),
		.quotient  (quotient),
		.remainder (remainder),
		.hilo_wr   (hilo_wr),
		.rd_hi     (rd_hi),
		.hilo_out  (hilo_out),
		.mul_out   (mul_out)
	);

endmodule

`default_nettype wire

//--- hdl/hilo_reg.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defs.svh"

module hilo_reg import md_pkg::*; (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   busy,
	input  wire logic                   finish,
	input  wire md_op_e                 op_q,
	input  wire logic [2*`MD_WIDTH-1:0] product,
	input  wire logic [`MD_WIDTH-1:0]   quotient,
	input  wire logic [`MD_WIDTH-1:0]   remainder,
	input  wire hilo_wr_t               hilo_wr,
	input  wire logic                   rd_hi,
	output logic [`MD_WIDTH-1:0]        hilo_out,
	output logic [`MD_WIDTH-1:0]        mul_out
);

	hilo_u hilo;

	always_ff @(posedge clk) begin
		if (!rst) begin
			hilo.acc <= '0;
			mul_out  <= '0;
		end else if (finish) begin
			case (op_q)
				OP_MULT, OP_MULTU: hilo.acc <= product;
				OP_MADD, OP_MADDU: hilo.acc <= hilo.acc + product;
				OP_MSUB, OP_MSUBU: hilo.acc <= hilo.acc - product;
				OP_DIV, OP_DIVU: begin
					hilo.halves.hi <= remainder;
					hilo.halves.lo <= quotient;
				end
				OP_MUL:  mul_out <= product[`MD_WIDTH-1:0]; // HI/LO untouched
				default: ;
			endcase
		end else if (hilo_wr.en && !busy) begin
			// a write while busy is dropped
			if (hilo_wr.sel_hi)
				hilo.halves.hi <= hilo_wr.data;
			else
				hilo.halves.lo <= hilo_wr.data;
		end
	end

	assign hilo_out = rd_hi ? hilo.halves.hi : hilo.halves.lo;

	// a second finish would accumulate twice
	a_finish_once: assert property (@(posedge clk) disable iff (!rst) finish |=> !finish);

endmodule

`default_nettype wire

//--- hdl/md_divider.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defs.svh"

module md_divider import md_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 go_div,
	input  wire md_op_e               op_q,
	input  wire logic [`MD_WIDTH-1:0] a_q,
	input  wire logic [`MD_WIDTH-1:0] b_q,
	input  wire logic [5:0]           step,
	output logic [`MD_WIDTH-1:0]      quotient,
	output logic [`MD_WIDTH-1:0]      remainder
);

	localparam int W = `MD_WIDTH;

	logic sgn;
	logic is_div;
	logic neg_quo;
	logic neg_rem;
	logic [W-1:0] quo; // dividend shifts out, quotient bits shift in
	logic [W-1:0] rem;
	logic [W-1:0] dvs;
	logic [W:0] rem_sh;
	logic [W:0] diff;

	assign sgn    = (op_q == OP_DIV);
	assign is_div = (op_q == OP_DIV) || (op_q == OP_DIVU);

	// trial subtract, sign bit of diff says restore
	assign rem_sh = {rem, quo[W-1]};
	assign diff   = rem_sh - {1'b0, dvs};

	always_ff @(posedge clk) begin
		if (!rst) begin
			neg_quo <= 1'b0;
			neg_rem <= 1'b0;
		end else if (go_div) begin
			neg_quo <= sgn && (a_q[W-1] ^ b_q[W-1]);
			neg_rem <= sgn && a_q[W-1]; // remainder follows dividend
		end
	end

	always_ff @(posedge clk) begin
		if (go_div) begin
			quo <= (sgn && a_q[W-1]) ? -a_q : a_q;
			dvs <= (sgn && b_q[W-1]) ? -b_q : b_q;
		end else if (is_div) begin
			if (step == 6'd0) begin
				rem <= '0;
			end else if (step <= 6'(`MD_DIV_STEPS)) begin
				if (!diff[W]) begin
					rem <= diff[W-1:0];
					quo <= {quo[W-2:0], 1'b1};
				end else begin
					rem <= rem_sh[W-1:0];
					quo <= {quo[W-2:0], 1'b0};
				end
			end
		end
	end

	// zero divisor needs no special case
	// every trial passes, giving all ones and the dividend
	assign quotient  = neg_quo ? -quo : quo;
	assign remainder = neg_rem ? -rem : rem;

endmodule

`default_nettype wire

//--- hdl/md_multiplier.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defs.svh"

module md_multiplier import md_pkg::*; (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   go_mul,
	input  wire md_op_e                 op_q,
	input  wire logic [`MD_WIDTH-1:0]   a_q,
	input  wire logic [`MD_WIDTH-1:0]   b_q,
	input  wire logic [5:0]             step,
	output logic [2*`MD_WIDTH-1:0]      product
);

	localparam int W = `MD_WIDTH;
	localparam int H = W / 2;

	logic sgn;
	logic neg_q;
	logic [W-1:0] a_mag;
	logic [W-1:0] b_mag;
	logic [2*W-1:0] acc;
	logic [H-1:0] a_half;
	logic [H-1:0] b_half;
	logic [W-1:0] pp;
	logic [2*W-1:0] pp_ext;

	always_comb begin
		case (op_q)
			OP_MULT, OP_MADD, OP_MSUB, OP_MUL: sgn = 1'b1;
			default:                           sgn = 1'b0;
		endcase
	end

	// step[0] picks the half of a, step[1] the half of b
	assign a_half = step[0] ? a_mag[W-1:H] : a_mag[H-1:0];
	assign b_half = step[1] ? b_mag[W-1:H] : b_mag[H-1:0];
	assign pp     = a_half * b_half;
	assign pp_ext = {{W{1'b0}}, pp} << (H * ({1'b0, step[0]} + {1'b0, step[1]}));

	always_ff @(posedge clk) begin
		if (!rst)
			neg_q <= 1'b0;
		else if (go_mul)
			neg_q <= sgn && (a_q[W-1] ^ b_q[W-1]); // exactly one negative
	end

	always_ff @(posedge clk) begin
		if (go_mul) begin
			a_mag <= (sgn && a_q[W-1]) ? -a_q : a_q;
			b_mag <= (sgn && b_q[W-1]) ? -b_q : b_q;
			acc   <= '0;
		end else if (step < 6'(`MD_MUL_CYCLES - 1)) begin
			acc <= acc + pp_ext;
		end
	end

	// finish step, sign goes back on
	assign product = neg_q ? -acc : acc;

endmodule

`default_nettype wire

//--- hdl/md_step_counter.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defs.svh"

module md_step_counter import md_pkg::*; (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic go_mul,
	input  wire logic go_div,
	output logic [5:0] step,
	output logic       last
);

	logic [5:0] count;
	logic kind_div; // kind of the running operation
	logic [5:0] lim;

	// mul: steps 0..4, div: steps 0..33
	assign lim = kind_div ? 6'(`MD_DIV_STEPS + 1) : 6'(`MD_MUL_CYCLES - 1);

	always_ff @(posedge clk) begin
		if (!rst) begin
			count    <= '0;
			kind_div <= 1'b0;
		end else if (go_mul || go_div) begin
			count    <= '0;
			kind_div <= go_div;
		end else if (count != lim) begin
			count <= count + 6'd1; // parks at the limit when done
		end
	end

	assign step = count;
	assign last = (count == lim);

	a_mul_len: assert property (@(posedge clk) disable iff (!rst)
		go_mul |-> ##(`MD_MUL_CYCLES) last);
	a_div_len: assert property (@(posedge clk) disable iff (!rst)
		go_div |-> ##(`MD_DIV_STEPS + 2) last);

endmodule

`default_nettype wire

//--- hdl/md_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "md_defs.svh"

module md_ctrl import md_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 start,
	input  wire logic                 kill,
	input  wire md_req_t              req,
	input  wire logic                 last,
	output logic                      busy,
	output logic                      go_mul,
	output logic                      go_div,
	output logic                      finish,
	output md_op_e                    op_q,
	output logic [`MD_WIDTH-1:0]      a_q,
	output logic [`MD_WIDTH-1:0]      b_q
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_MUL,
		S_DIV
	} state_e;

	state_e state;
	state_e state_n;
	logic accept;
	logic is_div;
	md_op_e op_r;
	logic [`MD_WIDTH-1:0] a_r;
	logic [`MD_WIDTH-1:0] b_r;

	always_comb begin
		case (req.op)
			OP_DIV, OP_DIVU: is_div = 1'b1;
			default:         is_div = 1'b0;
		endcase
	end

	assign accept = start && (state == S_IDLE) && !kill; // kill refuses the start
	assign go_mul = accept && !is_div;
	assign go_div = accept && is_div;

	always_comb begin
		state_n = state;
		case (state)
			S_IDLE: begin
				if (go_div)
					state_n = S_DIV;
				else if (go_mul)
					state_n = S_MUL;
			end
			S_MUL, S_DIV: begin
				if (last)
					state_n = S_IDLE;
			end
			default: state_n = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= S_IDLE;
			op_r  <= OP_MULT;
		end else begin
			state <= state_n;
			if (accept)
				op_r <= req.op;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			a_r <= req.a;
			b_r <= req.b;
		end
	end

	assign busy   = (state != S_IDLE);
	assign finish = busy && last; // final busy cycle

	// on the accept cycle the data paths see the new request directly,
	// so they can load it on the same edge as the latch
	assign op_q = accept ? req.op : op_r;
	assign a_q  = accept ? req.a : a_r;
	assign b_q  = accept ? req.b : b_r;

	// last parks high while idle, the counter must drop it on a start
	a_no_early_last: assert property (@(posedge clk) disable iff (!rst)
		(go_mul || go_div) |=> !last);

endmodule

`default_nettype wire

//--- hdl/md_pkg.sv
`default_nettype none

`include "md_defs.svh"

package md_pkg;

	// encodings follow the old ALU2Op field
	typedef enum logic [3:0] {
		OP_MULT  = 4'h0,
		OP_MULTU = 4'h1,
		OP_DIVU  = 4'h2,
		OP_DIV   = 4'h3,
		OP_MADDU = 4'h4,
		OP_MADD  = 4'h5,
		OP_MSUB  = 4'h6,
		OP_MSUBU = 4'h7,
		OP_MUL   = 4'h8
	} md_op_e;

	typedef struct packed {
		md_op_e              op;
		logic [`MD_WIDTH-1:0] a; // rs
		logic [`MD_WIDTH-1:0] b; // rt
	} md_req_t;

	// direct MTHI / MTLO style write
	typedef struct packed {
		logic                 en;
		logic                 sel_hi;
		logic [`MD_WIDTH-1:0] data;
	} hilo_wr_t;

	// HI/LO seen as one accumulator or as two words
	typedef union packed {
		logic [2*`MD_WIDTH-1:0] acc;
		struct packed {
			logic [`MD_WIDTH-1:0] hi;
			logic [`MD_WIDTH-1:0] lo;
		} halves;
	} hilo_u;

endpackage

`default_nettype wire

//--- hdl/md_defs.svh
`ifndef MD_DEFS_SVH
`define MD_DEFS_SVH

// operand and result word width
`define MD_WIDTH 32

// multiply class: four partial products plus one sign step
`define MD_MUL_CYCLES 5

// one quotient bit per step
// a division is busy for MD_DIV_STEPS + 2 cycles
`define MD_DIV_STEPS 32

`endif
